/* logic/c16_mem_pkg.sv */
//////////////////////////////
// C16 memory map definitions
// Data, address and bank widths, the CPU
// windows that the decode looks at and the
// names of the four system ROMs
//////////////////////////////

package c16_mem_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;

	// Offset inside one 16 KB ROM
	typedef logic [13:0] rom_addr_t;

	// Bank code, 1 and 3 select nothing
	typedef logic [1:0]  bank_t;

	// Which ROM answers an access, the low two bits index the ROM arrays
	typedef enum logic [2:0] {
		ROM_BASIC   = 3'd0,
		ROM_KERNAL  = 3'd1,
		ROM_FUNC_LO = 3'd2,
		ROM_FUNC_HI = 3'd3,
		ROM_NONE    = 3'd4
	} rom_sel_t;

	//////////////////////////////
	// Windows and codes
	//////////////////////////////

	// Standard and function ROM bank codes
	localparam bank_t BANK_STD  = 2'd0;
	localparam bank_t BANK_FUNC = 2'd2;

	// Bank register window FDD0-FDDF, upper 12 address bits
	localparam logic [11:0] BANK_WIN = 12'hFDD;

	// KERNAL page, always mapped while cs1 is active
	localparam byte_t KERN_PAGE = 8'hFC;

	// Open-bus window FDE0-FDFF, upper 11 address bits
	localparam logic [10:0] OPENBUS_WIN = {8'hFD, 3'b111};

	// Contribution of an unselected source to the wired-AND read bus
	localparam byte_t OPENBUS_FILL = 8'hFF;

endpackage

/* logic/c16_load_pkg.sv */
//////////////////////////////
// Host download definitions
// Slot codes of the host stream, the BASIC
// pointer locations patched after a program
// load and the loader states
//////////////////////////////

package c16_load_pkg;

	// Host stream byte offset
	typedef logic [24:0] dl_addr_t;

	// Download index codes
	localparam c16_mem_pkg::byte_t SLOT_PRG = 8'h01;
	localparam c16_mem_pkg::byte_t SLOT_ROM = 8'h03;

	// ROM image slots, from stream offset bits 24..14
	localparam logic [10:0] ROM_SLOT_KERNAL  = 11'd1;
	localparam logic [10:0] ROM_SLOT_BASIC   = 11'd2;
	localparam logic [10:0] ROM_SLOT_FUNC_LO = 11'd3;
	localparam logic [10:0] ROM_SLOT_FUNC_HI = 11'd4;

	// BASIC pointers that receive the program end address
	// Even entries take the low byte, odd entries the high byte
	localparam c16_mem_pkg::addr_t PTR_ADDRS [8] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_STREAM,
		LD_PATCH
	} load_state_t;

endpackage

/* logic/download_writer.sv */
//////////////////////////////
// Download writer
// Turns the host byte stream into RAM writes for
// a PRG load or ROM writes for ROM images, then
// patches the BASIC end pointers after a PRG
//////////////////////////////

`timescale 1ns/1ns

module download_writer
	import c16_mem_pkg::*;
	import c16_load_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,

	input  logic      dl_active_i,
	input  byte_t     dl_index_i,
	input  logic      dl_wr_i,
	input  dl_addr_t  dl_addr_i,
	input  byte_t     dl_data_i,

	output logic      ram_wr_o,
	output addr_t     ram_addr_o,
	output byte_t     ram_data_o,

	output logic      rom_wr_o,
	output rom_sel_t  rom_target_o,
	output rom_addr_t rom_addr_o,
	output byte_t     rom_data_o
);

	load_state_t state;

	// Next RAM address of the program, the end address once the stream stops
	addr_t      load_addr;
	logic [3:0] patch_cnt;

	logic       prg_active;
	logic       rom_active;
	rom_sel_t   rom_tgt;

	function automatic rom_sel_t slot_target(input logic [10:0] slot);
		case (slot)
			ROM_SLOT_KERNAL:  return ROM_KERNAL;
			ROM_SLOT_BASIC:   return ROM_BASIC;
			ROM_SLOT_FUNC_LO: return ROM_FUNC_LO;
			ROM_SLOT_FUNC_HI: return ROM_FUNC_HI;
			default:          return ROM_NONE;
		endcase
	endfunction

	assign prg_active = dl_active_i && (dl_index_i == SLOT_PRG);
	assign rom_active = dl_active_i && (dl_index_i == SLOT_ROM);
	assign rom_tgt    = slot_target(dl_addr_i[24:14]);

	//////////////////////////////
	// PRG stream and pointer patch
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= LD_IDLE;
			patch_cnt <= '0;
			ram_wr_o  <= 1'b0;
		end else begin
			ram_wr_o <= 1'b0;

			if (prg_active) begin
				state <= LD_STREAM;
				if (dl_wr_i) begin
					// First two bytes are the load address, low byte first
					if (dl_addr_i == dl_addr_t'(0)) begin
						load_addr[7:0] <= dl_data_i;
					end else if (dl_addr_i == dl_addr_t'(1)) begin
						load_addr[15:8] <= dl_data_i;
					end else begin
						ram_addr_o <= load_addr;
						ram_data_o <= dl_data_i;
						ram_wr_o   <= 1'b1;
						load_addr  <= load_addr + 16'd1;
					end
				end
			end else begin
				case (state)
					LD_STREAM: begin
						// Level fell, start the patch. Another index aborts it
						state     <= dl_active_i ? LD_IDLE : LD_PATCH;
						patch_cnt <= '0;
					end
					LD_PATCH: begin
						patch_cnt <= patch_cnt + 4'd1;
						// One pointer byte every other cycle
						if (!patch_cnt[0]) begin
							ram_addr_o <= PTR_ADDRS[patch_cnt[3:1]];
							ram_data_o <= patch_cnt[1] ? load_addr[15:8] : load_addr[7:0];
							ram_wr_o   <= 1'b1;
						end
						if (patch_cnt == 4'hF) begin
							state <= LD_IDLE;
						end
					end
					default: state <= LD_IDLE;
				endcase
			end
		end
	end

	//////////////////////////////
	// ROM images
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_wr_o <= 1'b0;
		end else begin
			rom_wr_o <= rom_active && dl_wr_i && (rom_tgt != ROM_NONE);
		end
		rom_target_o <= rom_tgt;
		rom_addr_o   <= dl_addr_i[13:0];
		rom_data_o   <= dl_data_i;
	end

endmodule

/* logic/rom_bank_ctrl.sv */
//////////////////////////////
// ROM bank control
// Plus/4 bank register at FDDx and the
// decode of the ROM that answers a CPU access
//////////////////////////////

`timescale 1ns/1ns

module rom_bank_ctrl
	import c16_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     model_i,

	input  addr_t    cpu_addr_i,
	input  logic     cpu_rnw_i,
	input  logic     cs0_i,
	input  logic     cs1_i,
	input  logic     cs_io_i,

	output rom_sel_t rom_read_sel_o
);

	// Plus/4 model, taken from model_i during reset
	logic  plus4;
	bank_t bank_lo;
	bank_t bank_hi;
	logic  cs_io_q;

	logic  bank_wr;
	logic  kern_hit;

	// CPU write to FDDx ends when cs_io drops
	assign bank_wr = plus4 && cs_io_q && !cs_io_i && !cpu_rnw_i
		&& (cpu_addr_i[15:4] == BANK_WIN);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			plus4   <= model_i;
			bank_lo <= BANK_STD;
			bank_hi <= BANK_STD;
			cs_io_q <= 1'b0;
		end else begin
			cs_io_q <= cs_io_i;
			if (bank_wr) begin
				bank_lo <= cpu_addr_i[1:0];
				bank_hi <= cpu_addr_i[3:2];
			end
		end
	end

	//////////////////////////////
	// Read select
	//////////////////////////////

	// FCxx is KERNAL whatever the high bank
	assign kern_hit = (cpu_addr_i[15:8] == KERN_PAGE);

	always_comb begin
		rom_read_sel_o = ROM_NONE;
		if (cs0_i) begin
			if (bank_lo == BANK_STD) begin
				rom_read_sel_o = ROM_BASIC;
			end else if (bank_lo == BANK_FUNC) begin
				rom_read_sel_o = ROM_FUNC_LO;
			end
		end else if (cs1_i) begin
			if (kern_hit || bank_hi == BANK_STD) begin
				rom_read_sel_o = ROM_KERNAL;
			end else if (bank_hi == BANK_FUNC) begin
				rom_read_sel_o = ROM_FUNC_HI;
			end
		end
	end

endmodule

/* logic/c16_memory.sv */
//////////////////////////////
// C16 memory arrays
// 64 KB main RAM, four 16 KB ROMs and the
// wired-AND CPU read bus with open-bus latch
//////////////////////////////

`timescale 1ns/1ns

module c16_memory
	import c16_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,

	// Download side
	input  logic      ram_wr_i,
	input  addr_t     ram_addr_i,
	input  byte_t     ram_data_i,
	input  logic      rom_wr_i,
	input  rom_sel_t  rom_target_i,
	input  rom_addr_t rom_addr_i,
	input  byte_t     rom_data_i,

	// CPU side
	input  addr_t     cpu_addr_i,
	input  byte_t     cpu_dout_i,
	input  logic      cpu_rnw_i,
	input  logic      cs_ram_i,
	input  rom_sel_t  rom_read_sel_i,
	output byte_t     cpu_din_o
);

	byte_t ram_mem [65536];

	// BASIC, KERNAL, function-low, function-high
	byte_t rom_mem [4][16384];

	logic  cs_ram_q;
	logic  cpu_ram_we;

	byte_t ram_q;
	byte_t rom_q;
	byte_t obus_latch;
	logic  obus_sel;
	byte_t obus_term;

	initial begin
		for (int r = 0; r < 4; r++) begin
			for (int a = 0; a < 16384; a++) begin
				rom_mem[r][a] = OPENBUS_FILL;
			end
		end
	end

	//////////////////////////////
	// RAM
	//////////////////////////////

	// CPU write lands on the cycle after cs_ram drops
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_ram_q   <= 1'b0;
			cpu_ram_we <= 1'b0;
		end else begin
			cs_ram_q   <= cs_ram_i;
			cpu_ram_we <= cs_ram_q && !cs_ram_i && !cpu_rnw_i;
		end
	end

	// Download port first, CPU port wins on a clash
	always_ff @(posedge clk_sys) begin
		if (ram_wr_i) begin
			ram_mem[ram_addr_i] <= ram_data_i;
		end
		if (cpu_ram_we) begin
			ram_mem[cpu_addr_i] <= cpu_dout_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		ram_q <= cs_ram_i ? ram_mem[cpu_addr_i] : OPENBUS_FILL;
	end

	//////////////////////////////
	// ROMs
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rom_wr_i && !rom_target_i[2]) begin
			rom_mem[rom_target_i[1:0]][rom_addr_i] <= rom_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_read_sel_i[2]) begin
			rom_q <= OPENBUS_FILL;
		end else begin
			rom_q <= rom_mem[rom_read_sel_i[1:0]][cpu_addr_i[13:0]];
		end
	end

	//////////////////////////////
	// Read bus
	//////////////////////////////

	// FDE0-FDFF returns whatever was last on the bus
	assign obus_sel  = (cpu_addr_i[15:5] == OPENBUS_WIN);
	assign obus_term = obus_sel ? obus_latch : OPENBUS_FILL;

	always_ff @(posedge clk_sys) begin
		obus_latch <= cpu_din_o;
	end

	assign cpu_din_o = ram_q & rom_q & obus_term;

endmodule

/* logic/c16_mem_top.sv */
//////////////////////////////
// C16 memory subsystem
// Download writer and bank control
// feeding the RAM and ROM arrays
//////////////////////////////

`timescale 1ns/1ns

module c16_mem_top
	import c16_mem_pkg::*;
	import c16_load_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     model_i,

	// Host stream
	input  logic     dl_active_i,
	input  byte_t    dl_index_i,
	input  logic     dl_wr_i,
	input  dl_addr_t dl_addr_i,
	input  byte_t    dl_data_i,

	// CPU bus
	input  addr_t    cpu_addr_i,
	input  byte_t    cpu_dout_i,
	input  logic     cpu_rnw_i,
	input  logic     cs_ram_i,
	input  logic     cs0_i,
	input  logic     cs1_i,
	input  logic     cs_io_i,
	output byte_t    cpu_din_o
);

	logic      ram_wr;
	addr_t     ram_addr;
	byte_t     ram_data;
	logic      rom_wr;
	rom_sel_t  rom_target;
	rom_addr_t rom_addr;
	byte_t     rom_data;
	rom_sel_t  rom_read_sel;

	download_writer u_writer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.ram_wr_o     (ram_wr),
		.ram_addr_o   (ram_addr),
		.ram_data_o   (ram_data),
		.rom_wr_o     (rom_wr),
		.rom_target_o (rom_target),
		.rom_addr_o   (rom_addr),
		.rom_data_o   (rom_data)
	);

	rom_bank_ctrl u_bank (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.model_i        (model_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_rnw_i      (cpu_rnw_i),
		.cs0_i          (cs0_i),
		.cs1_i          (cs1_i),
		.cs_io_i        (cs_io_i),
		.rom_read_sel_o (rom_read_sel)
	);

	c16_memory u_memory (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ram_wr_i       (ram_wr),
		.ram_addr_i     (ram_addr),
		.ram_data_i     (ram_data),
		.rom_wr_i       (rom_wr),
		.rom_target_i   (rom_target),
		.rom_addr_i     (rom_addr),
		.rom_data_i     (rom_data),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_dout_i     (cpu_dout_i),
		.cpu_rnw_i      (cpu_rnw_i),
		.cs_ram_i       (cs_ram_i),
		.rom_read_sel_i (rom_read_sel),
		.cpu_din_o      (cpu_din_o)
	);

endmodule

/* bench/tb_c16_mem.sv */
//////////////////////////////
// Testbench for the C16 memory subsystem
// Host downloads, ROM banking and CPU reads
// and writes against a reference model
//////////////////////////////

`timescale 1ns/1ns

module tb_c16_mem
	import c16_mem_pkg::*;
	import c16_load_pkg::*;
();

	localparam int PRG_MAX   = 320;
	localparam int IMG_LEN   = 16384;
	localparam int ROM_READS = 48;

	// Cycle budget of each test and the run limit of twice their sum
	localparam int PRG_CYCLES  = PRG_MAX + 24 + 2 * (PRG_MAX + 8);
	localparam int ROM_CYCLES  = 4 * (IMG_LEN + 2) + 8 + 4 * ROM_READS;
	localparam int BANK_CYCLES = 32 + 12 * 2 * ROM_READS;
	localparam int RAM_CYCLES  = 8 * 10;
	localparam int TIMEOUT_CYCLES = 2 * (PRG_CYCLES + ROM_CYCLES + BANK_CYCLES + RAM_CYCLES);

	// Reference ROM images
	localparam int IMG_BASIC  = 0;
	localparam int IMG_KERNAL = 1;
	localparam int IMG_FLO    = 2;
	localparam int IMG_FHI    = 3;
	localparam int IMG_NONE   = 4;

	logic     clk_sys;
	logic     reset;
	logic     model_i;
	logic     dl_active_i;
	byte_t    dl_index_i;
	logic     dl_wr_i;
	dl_addr_t dl_addr_i;
	byte_t    dl_data_i;
	addr_t    cpu_addr_i;
	byte_t    cpu_dout_i;
	logic     cpu_rnw_i;
	logic     cs_ram_i;
	logic     cs0_i;
	logic     cs1_i;
	logic     cs_io_i;
	byte_t    cpu_din_o;

	byte_t ram_ref [65536];
	byte_t rom_ref [4][16384];
	logic  ref_plus4 = 1'b0;
	bank_t ref_lo = 2'd0;
	bank_t ref_hi = 2'd0;

	logic [16:0] lfsr_state = 17'd94793;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	logic bus_idle;

	c16_mem_top dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model_i     (model_i),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_dout_i  (cpu_dout_i),
		.cpu_rnw_i   (cpu_rnw_i),
		.cs_ram_i    (cs_ram_i),
		.cs0_i       (cs0_i),
		.cs1_i       (cs1_i),
		.cs_io_i     (cs_io_i),
		.cpu_din_o   (cpu_din_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// Random data
	//////////////////////////////

	// Taps 17 and 14
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic byte_t image_byte(input int img, input rom_addr_t off);
		if (img == IMG_NONE) begin
			return 8'hFF;
		end
		return rom_ref[img][off];
	endfunction

	//////////////////////////////
	// Bus checks
	//////////////////////////////

	// Nothing selected outside the open-bus window reads as all ones
	assign bus_idle = !cs_ram_i && !cs0_i && !cs1_i && (cpu_addr_i[15:5] != OPENBUS_WIN);

	idle_bus_ff: assert property (@(posedge clk_sys) disable iff (reset)
		($past(bus_idle) && bus_idle) |-> (cpu_din_o == 8'hFF))
	else begin
		errors++;
		$display("FAIL idle_bus: addr %h expected ff actual %h", cpu_addr_i, cpu_din_o);
	end

	task automatic cpu_read(input string name, input addr_t addr, input logic sel_ram,
			input logic sel0, input logic sel1, input byte_t exp);
		byte_t got;
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_rnw_i  <= 1'b1;
		cs_ram_i   <= sel_ram;
		cs0_i      <= sel0;
		cs1_i      <= sel1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		got = cpu_din_o;
		checks++;
		read_value: assert (got == exp) else begin
			errors++;
			$display("FAIL %s: addr %h expected %h actual %h", name, addr, exp, got);
		end
	endtask

	task automatic cpu_write(input addr_t addr, input byte_t data);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_dout_i <= data;
		cpu_rnw_i  <= 1'b0;
		cs_ram_i   <= 1'b1;
		cs0_i      <= 1'b0;
		cs1_i      <= 1'b0;
		@(posedge clk_sys);
		cs_ram_i <= 1'b0;
		// Address and data held until the write lands
		repeat (2) @(posedge clk_sys);
		cpu_rnw_i <= 1'b1;
		ram_ref[addr] = data;
	endtask

	task automatic bank_write(input addr_t addr);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_rnw_i  <= 1'b0;
		cs_io_i    <= 1'b1;
		cs_ram_i   <= 1'b0;
		cs0_i      <= 1'b0;
		cs1_i      <= 1'b0;
		@(posedge clk_sys);
		cs_io_i <= 1'b0;
		@(posedge clk_sys);
		cpu_rnw_i <= 1'b1;
		if (ref_plus4 && addr[15:4] == 12'hFDD) begin
			ref_lo = addr[1:0];
			ref_hi = addr[3:2];
		end
	endtask

	task automatic apply_reset(input logic model);
		@(posedge clk_sys);
		reset   <= 1'b1;
		model_i <= model;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		ref_plus4 = model;
		ref_lo = 2'd0;
		ref_hi = 2'd0;
	endtask

	// Expected ROM follows the reference banks while FCxx stays KERNAL
	task automatic rom_reads(input string name, input logic use_cs1);
		logic [31:0] rnd;
		rom_addr_t off;
		addr_t addr;
		int img;
		for (int i = 0; i < ROM_READS; i++) begin
			rnd = take_bits(14);
			off = rnd[13:0];
			if (use_cs1 && (i % 4 == 0)) begin
				off[13:8] = 6'h3C;
			end
			// FDE0-FDFF reads the open-bus latch, keep ROM reads below it
			if (use_cs1 && ({2'b11, off[13:5]} == OPENBUS_WIN)) begin
				off[5] = 1'b0;
			end
			addr = use_cs1 ? {2'b11, off} : {2'b10, off};
			if (!use_cs1) begin
				img = (ref_lo == 2'd0) ? IMG_BASIC : (ref_lo == 2'd2) ? IMG_FLO : IMG_NONE;
			end else if (addr[15:8] == 8'hFC || ref_hi == 2'd0) begin
				img = IMG_KERNAL;
			end else begin
				img = (ref_hi == 2'd2) ? IMG_FHI : IMG_NONE;
			end
			cpu_read(name, addr, 1'b0, !use_cs1, use_cs1, image_byte(img, off));
		end
	endtask

	//////////////////////////////
	// Host stream
	//////////////////////////////

	task automatic host_start(input byte_t index);
		@(posedge clk_sys);
		dl_index_i  <= index;
		dl_active_i <= 1'b1;
	endtask

	task automatic host_byte(input dl_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		dl_wr_i   <= 1'b1;
		dl_addr_i <= addr;
		dl_data_i <= data;
	endtask

	task automatic host_stop();
		@(posedge clk_sys);
		dl_wr_i     <= 1'b0;
		dl_active_i <= 1'b0;
	endtask

	task automatic load_rom(input logic [10:0] slot, input int img);
		logic [31:0] rnd;
		host_start(SLOT_ROM);
		for (int a = 0; a < IMG_LEN; a++) begin
			rnd = take_bits(8);
			rom_ref[img][a] = rnd[7:0];
			host_byte({slot, a[13:0]}, rnd[7:0]);
		end
		host_stop();
	endtask

	task automatic prg_test();
		logic [31:0] rnd;
		addr_t start;
		addr_t end_addr;
		int len;
		rnd = take_bits(14);
		start = 16'h1000 + {2'b00, rnd[13:0]};
		rnd = take_bits(8);
		len = 64 + int'(rnd[7:0]);
		host_start(SLOT_PRG);
		host_byte(25'd0, start[7:0]);
		host_byte(25'd1, start[15:8]);
		for (int i = 0; i < len; i++) begin
			rnd = take_bits(8);
			ram_ref[start + 16'(i)] = rnd[7:0];
			host_byte(dl_addr_t'(i + 2), rnd[7:0]);
		end
		host_stop();
		// End pointers get the next unwritten address
		end_addr = start + 16'(len);
		for (int p = 0; p < 8; p++) begin
			ram_ref[PTR_ADDRS[p]] = p[0] ? end_addr[15:8] : end_addr[7:0];
		end
		repeat (20) @(posedge clk_sys);
		for (int i = 0; i < len; i++) begin
			cpu_read("prg_readback", start + 16'(i), 1'b1, 1'b0, 1'b0,
				ram_ref[start + 16'(i)]);
		end
		for (int p = 0; p < 8; p++) begin
			cpu_read("ptr_patch", PTR_ADDRS[p], 1'b1, 1'b0, 1'b0, ram_ref[PTR_ADDRS[p]]);
		end
	endtask

	task automatic ram_openbus_test();
		logic [31:0] rnd;
		addr_t addr;
		byte_t d;
		for (int i = 0; i < 8; i++) begin
			rnd = take_bits(21);
			addr = {3'b011, rnd[12:0]};
			d = rnd[20:13];
			cpu_write(addr, d);
			cpu_read("cpu_ram_write", addr, 1'b1, 1'b0, 1'b0, d);
			// FDE0-FDFF with nothing selected repeats the last bus value
			rnd = take_bits(5);
			cpu_read("open_bus", {8'hFD, 3'b111, rnd[4:0]}, 1'b0, 1'b0, 1'b0, d);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		reset       = 1'b1;
		model_i     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = 8'h00;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = 8'h00;
		cpu_addr_i  = 16'h0000;
		cpu_dout_i  = 8'h00;
		cpu_rnw_i   = 1'b1;
		cs_ram_i    = 1'b0;
		cs0_i       = 1'b0;
		cs1_i       = 1'b0;
		cs_io_i     = 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		prg_test();

		load_rom(ROM_SLOT_BASIC, IMG_BASIC);
		load_rom(ROM_SLOT_KERNAL, IMG_KERNAL);
		load_rom(ROM_SLOT_FUNC_LO, IMG_FLO);
		load_rom(ROM_SLOT_FUNC_HI, IMG_FHI);
		apply_reset(1'b0);
		rom_reads("default_basic", 1'b0);
		rom_reads("default_kernal", 1'b1);

		// Plus/4 banking
		apply_reset(1'b1);
		bank_write(16'hFDD2);
		rom_reads("bank_func_lo", 1'b0);
		rom_reads("bank_hi_std", 1'b1);
		bank_write(16'hFDD8);
		rom_reads("bank_func_hi", 1'b1);
		rom_reads("bank_lo_std", 1'b0);
		bank_write(16'hFDD1);
		rom_reads("bank_lo_code1", 1'b0);
		bank_write(16'hFDD4);
		rom_reads("bank_hi_code1", 1'b1);
		apply_reset(1'b1);
		rom_reads("reset_basic", 1'b0);
		rom_reads("reset_kernal", 1'b1);

		// C16 model ignores the bank register
		apply_reset(1'b0);
		bank_write(16'hFDD2);
		bank_write(16'hFDDA);
		rom_reads("c16_basic", 1'b0);
		rom_reads("c16_kernal", 1'b1);

		ram_openbus_test();

		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d, reads checked: %0d", errors, checks);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout: run still going after %0d cycles", cycle_cnt);
		$display("Test failed");
		$finish;
	end

endmodule

/* all.f */
logic/c16_mem_pkg.sv
logic/c16_load_pkg.sv
logic/download_writer.sv
logic/rom_bank_ctrl.sv
logic/c16_memory.sv
logic/c16_mem_top.sv
bench/tb_c16_mem.sv

/* Makefile */
# Verilator build and run of the C16 memory testbench

VERILATOR ?= verilator
TOP       ?= tb_c16_mem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
